// File: hdl/zx_mem_config.svh
//==================================================
// Bus, page and memory address widths
// Port addresses of the 7FFD, 1FFD and FE ports
//==================================================
`ifndef ZX_MEM_CONFIG_SVH
`define ZX_MEM_CONFIG_SVH

`define ZX_CPU_ADDR_W 16
`define ZX_DATA_W     8
`define ZX_PAGE_OFS_W 14
// ROM flag, 3-bit page, 14-bit offset
`define ZX_MEM_ADDR_W 18

`define ZX_PORT_7FFD  16'h7FFD
`define ZX_PORT_1FFD  16'h1FFD
`define ZX_PORT_FE    16'h00FE
`endif

// File: hdl/zx_mem_pkg.sv
//==================================================
// Shared types of the paging core
// Machine model, RAM page and ROM page numbers
//==================================================

package zx_mem_pkg;

	//==================================================
	// Machine model
	//==================================================
	// Sampled once at reset; 48K has paging locked
	typedef enum logic [1:0] {
		MODEL_48K   = 2'd0,
		MODEL_128K  = 2'd1,
		MODEL_PLUS3 = 2'd2
	} zx_model_t;

	//==================================================
	// Page numbers
	//==================================================
	// Eight 16 KB RAM pages
	typedef logic [2:0] ram_page_t;

	// Four 16 KB ROM pages
	// 48K and 128K only ever reach pages 0 and 1
	typedef logic [1:0] rom_page_t;

endpackage

// File: hdl/zx_port_decoder.sv
//==================================================
// Z80 bus port decoder
// Finds the first cycle of each I/O write and turns
// it into a one-cycle strobe for the 7FFD, 1FFD or
// FE port, with the written data captured alongside
//==================================================
`timescale 1ns/10ps
`include "zx_mem_config.svh"

module zx_port_decoder (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [`ZX_CPU_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0]     dout,
	input  logic                      iorq_n,
	input  logic                      wr_n,
	input  logic                      m1_n,
	input  zx_mem_pkg::zx_model_t     model,
	output logic                      page_wr,
	output logic                      plus3_wr,
	output logic                      ula_wr,
	output logic [`ZX_DATA_W-1:0]     wr_data
);
	import zx_mem_pkg::*;

	logic io_wr;
	logic io_wr_d;
	logic io_wr_start;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_fe;

	// I/O write, interrupt acknowledge excluded
	assign io_wr       = ~iorq_n & ~wr_n & m1_n;
	assign io_wr_start = io_wr & ~io_wr_d;

	//==================================================
	// Partial address decode
	//==================================================
	// A14 only matters on +3, where it separates 7FFD from 1FFD
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | (model != MODEL_PLUS3));
	assign sel_1ffd = (model == MODEL_PLUS3) & (addr[15:12] == 4'b0001) & ~addr[1];
	assign sel_fe   = ~addr[0];

	// Paging ports win over the ULA port
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d  <= 1'b0;
			page_wr  <= 1'b0;
			plus3_wr <= 1'b0;
			ula_wr   <= 1'b0;
		end else begin
			io_wr_d  <= io_wr;
			page_wr  <= io_wr_start & sel_7ffd;
			plus3_wr <= io_wr_start & sel_1ffd & ~sel_7ffd;
			ula_wr   <= io_wr_start & sel_fe & ~sel_7ffd & ~sel_1ffd;
		end
	end

	// Data travels with the strobe
	always_ff @(posedge clk_sys) begin
		if (io_wr_start) begin
			wr_data <= dout;
		end
	end

	// Only one port is written per bus cycle
	a_strobe_onehot: assert property (
		@(posedge clk_sys) disable iff (reset)
		$onehot0({page_wr, plus3_wr, ula_wr})
	);

endmodule

// File: hdl/zx_page_regs.sv
//==================================================
// Paging register bank
// 7FFD and 1FFD paging state, paging lock, latched
// machine model and the ULA border, EAR and MIC bits
//==================================================
`timescale 1ns/10ps
`include "zx_mem_config.svh"

module zx_page_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_mem_pkg::zx_model_t model_in,
	input  logic                  page_wr,
	input  logic                  plus3_wr,
	input  logic                  ula_wr,
	input  logic [`ZX_DATA_W-1:0] wr_data,
	output zx_mem_pkg::zx_model_t model,
	output zx_mem_pkg::ram_page_t page_ram,
	output zx_mem_pkg::rom_page_t rom_page,
	output logic                  special_en,
	output logic [1:0]            special_cfg,
	output logic [2:0]            border,
	output logic                  ear,
	output logic                  mic
);
	import zx_mem_pkg::*;

	// 7FFD bit 4, 128K ROM select
	logic       rom_lo;
	// 1FFD bits 2..0
	logic [2:0] reg_1ffd;
	logic       page_lock;

	//==================================================
	// Paging registers
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model     <= model_in;
			page_ram  <= '0;
			rom_lo    <= 1'b0;
			reg_1ffd  <= '0;
			page_lock <= (model_in == MODEL_48K);
		end else begin
			if (page_wr && !page_lock) begin
				page_ram  <= wr_data[2:0];
				rom_lo    <= wr_data[4];
				// Bit 5 locks paging until the next reset
				page_lock <= wr_data[5];
			end
			if (plus3_wr && !page_lock) begin
				reg_1ffd <= wr_data[2:0];
			end
		end
	end

	//==================================================
	// ULA port
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= '0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (ula_wr) begin
			border <= wr_data[2:0];
			mic    <= wr_data[3];
			ear    <= wr_data[4];
		end
	end

	// ROM page by model
	always_comb begin
		case (model)
			MODEL_128K:  rom_page = {1'b0, rom_lo};
			MODEL_PLUS3: rom_page = {reg_1ffd[2], rom_lo};
			default:     rom_page = '0;
		endcase
	end

	assign special_en  = reg_1ffd[0];
	assign special_cfg = reg_1ffd[2:1];

	// Lock is sticky, only reset releases it
	a_lock_sticky: assert property (
		@(posedge clk_sys) disable iff (reset)
		page_lock |=> page_lock
	);

endmodule

// File: hdl/zx_addr_map.sv
//==================================================
// CPU address to flat memory address mapper
// Normal and +3 special paging, ROM write blocking
// and the memory read and write strobes
//==================================================
`timescale 1ns/10ps
`include "zx_mem_config.svh"

module zx_addr_map (
	input  logic                      clk_sys,
	input  logic [`ZX_CPU_ADDR_W-1:0] addr,
	input  logic                      mreq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  zx_mem_pkg::ram_page_t     page_ram,
	input  zx_mem_pkg::rom_page_t     rom_page,
	input  logic                      special_en,
	input  logic [1:0]                special_cfg,
	output logic [`ZX_MEM_ADDR_W-1:0] mem_addr,
	output logic                      mem_rd,
	output logic                      mem_we
);
	import zx_mem_pkg::*;

	logic [1:0] quarter;
	logic       rom_flag;
	ram_page_t  page;

	assign quarter = addr[`ZX_CPU_ADDR_W-1:`ZX_PAGE_OFS_W];

	//==================================================
	// Page selection
	//==================================================
	always_comb begin
		rom_flag = 1'b0;
		page     = '0;
		if (!special_en) begin
			case (quarter)
				2'd0: begin
					rom_flag = 1'b1;
					page     = {1'b0, rom_page};
				end
				2'd1:    page = 3'd5;
				2'd2:    page = 3'd2;
				default: page = page_ram;
			endcase
		end else begin
			// All-RAM configurations of the +3
			case (special_cfg)
				2'd0:    page = {1'b0, quarter};
				2'd1:    page = {1'b1, quarter};
				2'd2:    page = (quarter == 2'd3) ? 3'd3 : {1'b1, quarter};
				default: begin
					if (quarter == 2'd1) begin
						page = 3'd7;
					end else if (quarter == 2'd3) begin
						page = 3'd3;
					end else begin
						page = {1'b1, quarter};
					end
				end
			endcase
		end
	end

	assign mem_addr = {rom_flag, page, addr[`ZX_PAGE_OFS_W-1:0]};
	assign mem_rd   = ~mreq_n & ~rd_n;
	// ROM is read only
	assign mem_we   = ~mreq_n & ~wr_n & ~rom_flag;

	// ROM region is never written
	a_rom_no_write: assert property (
		@(posedge clk_sys)
		!(mem_we && mem_addr[`ZX_MEM_ADDR_W-1])
	);

endmodule

// File: hdl/zx_mem_top.sv
//==================================================
// Memory paging core top level
// Port decoder, paging register bank, address mapper
//==================================================
`timescale 1ns/10ps
`include "zx_mem_config.svh"

module zx_mem_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  zx_mem_pkg::zx_model_t     model,
	input  logic [`ZX_CPU_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0]     dout,
	input  logic                      mreq_n,
	input  logic                      iorq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  logic                      m1_n,
	output logic [`ZX_MEM_ADDR_W-1:0] mem_addr,
	output logic                      mem_rd,
	output logic                      mem_we,
	output logic [2:0]                border,
	output logic                      ear,
	output logic                      mic
);
	import zx_mem_pkg::*;

	logic                  page_wr;
	logic                  plus3_wr;
	logic                  ula_wr;
	logic [`ZX_DATA_W-1:0] wr_data;
	zx_model_t             model_lat;
	ram_page_t             page_ram;
	rom_page_t             rom_page;
	logic                  special_en;
	logic [1:0]            special_cfg;

	// Decoder follows the model latched at reset
	zx_port_decoder u_port_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.addr    (addr),
		.dout    (dout),
		.iorq_n  (iorq_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.model   (model_lat),
		.page_wr (page_wr),
		.plus3_wr(plus3_wr),
		.ula_wr  (ula_wr),
		.wr_data (wr_data)
	);

	zx_page_regs u_page_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.model_in   (model),
		.page_wr    (page_wr),
		.plus3_wr   (plus3_wr),
		.ula_wr     (ula_wr),
		.wr_data    (wr_data),
		.model      (model_lat),
		.page_ram   (page_ram),
		.rom_page   (rom_page),
		.special_en (special_en),
		.special_cfg(special_cfg),
		.border     (border),
		.ear        (ear),
		.mic        (mic)
	);

	zx_addr_map u_addr_map (
		.clk_sys    (clk_sys),
		.addr       (addr),
		.mreq_n     (mreq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.page_ram   (page_ram),
		.rom_page   (rom_page),
		.special_en (special_en),
		.special_cfg(special_cfg),
		.mem_addr   (mem_addr),
		.mem_rd     (mem_rd),
		.mem_we     (mem_we)
	);

endmodule

// File: sim/tb_zx_mem.sv
//==================================================
// Testbench for the memory paging core
// Clock, reset, DUT instance, reference paging
// model and directed test tasks
//==================================================
`timescale 1ns/10ps
`include "zx_mem_config.svh"

module tb_zx_mem;
	import zx_mem_pkg::*;

	logic                      clk_sys;
	logic                      reset;
	zx_model_t                 model;
	logic [`ZX_CPU_ADDR_W-1:0] addr;
	logic [`ZX_DATA_W-1:0]     dout;
	logic                      mreq_n;
	logic                      iorq_n;
	logic                      rd_n;
	logic                      wr_n;
	logic                      m1_n;
	logic [`ZX_MEM_ADDR_W-1:0] mem_addr;
	logic                      mem_rd;
	logic                      mem_we;
	logic [2:0]                border;
	logic                      ear;
	logic                      mic;

	// Reference paging state
	zx_model_t  ref_model;
	logic [2:0] ref_page;
	logic       ref_rom_lo;
	logic [2:0] ref_1ffd;
	logic       ref_lock;

	int checks;
	int errors;

	zx_mem_top zx_mem_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Whole run is bounded
	initial begin
		#200000;
		$display("Timeout: the run did not finish within 200 us");
		$display("=== FAIL ===");
		$finish;
	end

	//==================================================
	// Helpers
	//==================================================
	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic apply_reset(input zx_model_t m);
		model = m;
		reset = 1'b1;
		wait_cycles(16);
		reset      = 1'b0;
		ref_model  = m;
		ref_page   = '0;
		ref_rom_lo = 1'b0;
		ref_1ffd   = '0;
		ref_lock   = (m == MODEL_48K);
	endtask

	// Page set of the +3 all-RAM modes, quarter 0 in the low slot
	function automatic logic [2:0] special_page(input logic [1:0] cfg, input logic [1:0] q);
		logic [11:0] set;
		case (cfg)
			2'd0:    set = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    set = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    set = {3'd3, 3'd6, 3'd5, 3'd4};
			default: set = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		return set[q*3 +: 3];
	endfunction

	function automatic logic [17:0] expected_addr(input logic [15:0] a);
		logic [1:0] rom;
		logic [2:0] pg;
		case (ref_model)
			MODEL_128K:  rom = {1'b0, ref_rom_lo};
			MODEL_PLUS3: rom = {ref_1ffd[2], ref_rom_lo};
			default:     rom = 2'd0;
		endcase
		if (ref_1ffd[0]) begin
			return {1'b0, special_page(ref_1ffd[2:1], a[15:14]), a[13:0]};
		end
		case (a[15:14])
			2'd0:    return {1'b1, 1'b0, rom, a[13:0]};
			2'd1:    pg = 3'd5;
			2'd2:    pg = 3'd2;
			default: pg = ref_page;
		endcase
		return {1'b0, pg, a[13:0]};
	endfunction

	// Port decode by address bits, paging ports before the ULA
	task automatic ref_port_write(input logic [15:0] a, input logic [7:0] d);
		logic sel_7ffd;
		logic sel_1ffd;
		sel_7ffd = !a[15] && !a[1] && (a[14] || ref_model != MODEL_PLUS3);
		sel_1ffd = (ref_model == MODEL_PLUS3) && (a[15:12] == 4'b0001) && !a[1];
		if (sel_7ffd) begin
			if (!ref_lock) begin
				ref_page   = d[2:0];
				ref_rom_lo = d[4];
				ref_lock   = d[5];
			end
		end else if (sel_1ffd && !ref_lock) begin
			ref_1ffd = d[2:0];
		end
	endtask

	//==================================================
	// Bus tasks
	//==================================================
	task automatic bus_io_write(input logic [15:0] a, input logic [7:0] d);
		addr   = a;
		dout   = d;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		wait_cycles(3);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		ref_port_write(a, d);
		wait_cycles(4);
	endtask

	task automatic check_map(input logic [1:0] q);
		logic [15:0] a;
		a      = {q, 14'($urandom)};
		addr   = a;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		@(posedge clk_sys);
		compare_value("mem_addr", 32'(mem_addr), 32'(expected_addr(a)));
		compare_value("mem_rd", 32'(mem_rd), 32'd1);
		@(negedge clk_sys);
		mreq_n = 1'b1;
		rd_n   = 1'b1;
	endtask

	task automatic check_all_quarters();
		for (int q = 0; q < 4; q++) begin
			check_map(2'(q));
		end
	endtask

	task automatic check_write(input logic [1:0] q, input logic exp_we);
		addr   = {q, 14'($urandom)};
		mreq_n = 1'b0;
		wr_n   = 1'b0;
		@(posedge clk_sys);
		compare_value("mem_we", 32'(mem_we), 32'(exp_we));
		compare_value("mem_rd", 32'(mem_rd), 32'd0);
		@(negedge clk_sys);
		mreq_n = 1'b1;
		wr_n   = 1'b1;
	endtask

	//==================================================
	// Directed tests
	//==================================================
	task automatic select_ram_rom();
		for (int i = 0; i < 6; i++) begin
			bus_io_write(`ZX_PORT_7FFD, 8'($urandom) & 8'hDF);
			check_map(2'd0);
			check_map(2'd3);
		end
	endtask

	task automatic lock_paging();
		logic [7:0] d;
		d = 8'h20 | (8'($urandom) & 8'h17);
		bus_io_write(`ZX_PORT_7FFD, d);
		check_all_quarters();
		// Both of these must be ignored
		bus_io_write(`ZX_PORT_7FFD, ~d & 8'hDF);
		bus_io_write(`ZX_PORT_1FFD, ~d);
		check_all_quarters();
		apply_reset(MODEL_128K);
		check_all_quarters();
		// Reset releases the lock
		bus_io_write(`ZX_PORT_7FFD, 8'h17);
		check_map(2'd0);
		check_map(2'd3);
	endtask

	task automatic plus3_special_paging();
		apply_reset(MODEL_PLUS3);
		for (int c = 0; c < 4; c++) begin
			bus_io_write(`ZX_PORT_1FFD, {5'b0, 2'(c), 1'b1});
			check_all_quarters();
		end
		for (int r = 0; r < 4; r++) begin
			bus_io_write(`ZX_PORT_1FFD, {5'b0, r[1], 2'b00});
			bus_io_write(`ZX_PORT_7FFD, {3'b0, r[0], 4'b0});
			check_map(2'd0);
		end
	endtask

	task automatic write_block_and_ula();
		logic [7:0] d;
		apply_reset(MODEL_128K);
		check_write(2'd0, 1'b0);
		check_write(2'd3, 1'b1);
		d = 8'($urandom);
		// Second write flips every bit
		for (int i = 0; i < 2; i++) begin
			bus_io_write(`ZX_PORT_FE, d);
			compare_value("border", 32'(border), 32'(d[2:0]));
			compare_value("mic", 32'(mic), 32'(d[3]));
			compare_value("ear", 32'(ear), 32'(d[4]));
			d = ~d;
		end
	endtask

	task automatic locked_48k_writes();
		apply_reset(MODEL_48K);
		bus_io_write(`ZX_PORT_7FFD, 8'($urandom) | 8'h17);
		bus_io_write(`ZX_PORT_1FFD, 8'($urandom) | 8'h05);
		check_all_quarters();
	endtask

	initial begin
		reset  = 1'b1;
		model  = MODEL_128K;
		addr   = '0;
		dout   = '0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		checks = 0;
		errors = 0;
		void'($urandom(32'h469ef672));
		@(negedge clk_sys);
		apply_reset(MODEL_128K);
		check_all_quarters();
		select_ram_rom();
		lock_paging();
		plus3_special_paging();
		write_block_and_ula();
		locked_48k_writes();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
hdl/zx_mem_pkg.sv
hdl/zx_port_decoder.sv
hdl/zx_page_regs.sv
hdl/zx_addr_map.sv
hdl/zx_mem_top.sv
sim/tb_zx_mem.sv

// File: Makefile
# Verilator build and run of the paging core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_zx_mem \
		-Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_zx_mem | tee sim.log
	@grep -q "^=== PASS ===$$" sim.log || (echo "Test failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log
